//--- design/lt100_pkg.sv
`default_nettype none

package lt100_pkg;

    // --------------------------------------------------
    // Bus widths
    // --------------------------------------------------
    localparam int ADDR_WIDTH   = 32;
    localparam int DATA_WIDTH   = 32;
    localparam int BE_WIDTH     = DATA_WIDTH / 8;
    localparam int REGION_WIDTH = 4;
    localparam int OFFSET_WIDTH = ADDR_WIDTH - REGION_WIDTH;

    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [BE_WIDTH-1:0]     be_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;
    typedef logic [REGION_WIDTH-1:0] region_t;

    // Region codes in the top address nibble
    localparam region_t REGION_BRAM  = 4'd0;
    localparam region_t REGION_TIMER = 4'd1;
    localparam region_t REGION_UART  = 4'd2;

    // Scratch RAM size in words and bytes
    localparam int BRAM_DEPTH = 256;
    localparam int BRAM_BYTES = BRAM_DEPTH * BE_WIDTH;

    // Timer register map
    localparam offset_t TMR_CTRL    = 28'h0;
    localparam offset_t TMR_PERIOD  = 28'h4;
    localparam offset_t TMR_COMPARE = 28'h8;
    localparam offset_t TMR_COUNT   = 28'hC;
    localparam offset_t TMR_STATUS  = 28'h10;
    localparam int      TMR_CTRL_RUN    = 0;
    localparam int      TMR_CTRL_IRQ_EN = 1;

    // UART register map
    localparam offset_t UART_TXDATA = 28'h0;
    localparam offset_t UART_STATUS = 28'h4;
    localparam offset_t UART_RXDATA = 28'h8;
    localparam offset_t UART_DIV    = 28'hC;
    localparam int      UART_STAT_TX_BUSY  = 0;
    localparam int      UART_STAT_RX_VALID = 1;
    localparam data_t   UART_DIV_RESET     = 32'd16;

    // Request shared by all peripherals
    typedef struct packed {
        logic    wr_en;
        offset_t offset;
        data_t   data;
        be_t     be;
    } lt100_req_t;

    // Response from one peripheral
    typedef struct packed {
        logic  ready;
        data_t data;
        logic  irq;
        logic  bus_err;
    } lt100_rsp_t;

    typedef enum logic {
        BUS_IDLE,
        BUS_WAIT
    } bus_state_t;

endpackage

`default_nettype wire

//--- design/sp_bram.sv
`timescale 1ns/1ps
`default_nettype none

module sp_bram (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       i_enable,
    input  wire lt100_pkg::lt100_req_t i_req,
    output lt100_pkg::lt100_rsp_t     o_rsp
);
    import lt100_pkg::*;

    data_t      mem [BRAM_DEPTH];
    lt100_req_t req_q;
    logic       acc_q;
    logic       in_range;
    logic       rsp_ready;
    logic       rsp_err;
    data_t      rsp_data;
    logic [$clog2(BRAM_DEPTH)-1:0] word_idx;

    assign in_range = (req_q.offset < offset_t'(BRAM_BYTES));
    assign word_idx = req_q.offset[$clog2(BRAM_DEPTH)+1:2];

    always_ff @(posedge clk) begin
        if (i_enable) begin
            req_q <= i_req;
        end
    end

    // Access runs one edge after the strobe and ready follows on the next
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_q     <= 1'b0;
            rsp_ready <= 1'b0;
            rsp_err   <= 1'b0;
        end else begin
            acc_q     <= i_enable;
            rsp_ready <= acc_q;
            rsp_err   <= acc_q && !in_range;
        end
    end

    // Read-first with each byte lane written on its own
    always_ff @(posedge clk) begin
        if (acc_q && in_range) begin
            if (req_q.wr_en) begin
                for (int b = 0; b < BE_WIDTH; b++) begin
                    if (req_q.be[b]) begin
                        mem[word_idx][8*b +: 8] <= req_q.data[8*b +: 8];
                    end
                end
            end
            rsp_data <= mem[word_idx];
        end
    end

    assign o_rsp = '{ready: rsp_ready, data: rsp_data, irq: 1'b0, bus_err: rsp_err};

    // Ready is a single-cycle pulse per strobe
    a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_ready |=> !rsp_ready);

endmodule

`default_nettype wire

//--- design/timer_mem.sv
`timescale 1ns/1ps
`default_nettype none

module timer_mem (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        i_enable,
    input  wire lt100_pkg::lt100_req_t i_req,
    output lt100_pkg::lt100_rsp_t      o_rsp,
    output logic                       o_pwm
);
    import lt100_pkg::*;

    lt100_req_t req_q;
    logic       acc_q;
    logic       run;
    logic       irq_en;
    logic       wrap_flag;
    data_t      period;
    data_t      compare;
    data_t      count;
    data_t      rd_data;
    logic       bad;
    logic       rsp_ready;
    logic       rsp_err;
    data_t      rsp_data;

    function automatic data_t be_merge(data_t old_val, data_t new_val, be_t be);
        data_t merged;
        merged = old_val;
        for (int b = 0; b < BE_WIDTH; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return merged;
    endfunction

    always_ff @(posedge clk) begin
        if (i_enable) begin
            req_q <= i_req;
        end
    end

    // --------------------------------------------------
    // Register decode
    // --------------------------------------------------
    always_comb begin
        rd_data = '0;
        bad     = 1'b0;
        case (req_q.offset)
            TMR_CTRL: begin
                rd_data[TMR_CTRL_RUN]    = run;
                rd_data[TMR_CTRL_IRQ_EN] = irq_en;
            end
            TMR_PERIOD:  rd_data = period;
            TMR_COMPARE: rd_data = compare;
            TMR_COUNT: begin
                rd_data = count;
                bad     = req_q.wr_en;
            end
            TMR_STATUS:  rd_data[0] = wrap_flag;
            default:     bad = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_q     <= 1'b0;
            rsp_ready <= 1'b0;
            rsp_err   <= 1'b0;
            run       <= 1'b0;
            irq_en    <= 1'b0;
            wrap_flag <= 1'b0;
            period    <= '0;
            compare   <= '0;
            count     <= '0;
        end else begin
            acc_q     <= i_enable;
            rsp_ready <= acc_q;
            rsp_err   <= acc_q && bad;
            if (acc_q && req_q.wr_en && !bad) begin
                case (req_q.offset)
                    TMR_CTRL: begin
                        run    <= req_q.data[TMR_CTRL_RUN];
                        irq_en <= req_q.data[TMR_CTRL_IRQ_EN];
                    end
                    TMR_PERIOD:  period  <= be_merge(period, req_q.data, req_q.be);
                    TMR_COMPARE: compare <= be_merge(compare, req_q.data, req_q.be);
                    TMR_STATUS: begin
                        if (req_q.data[0]) begin
                            wrap_flag <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
            // Counter, a wrap on the same edge beats the clear
            if (!run) begin
                count <= '0;
            end else if (count >= period) begin
                count     <= '0;
                wrap_flag <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_q) begin
            rsp_data <= rd_data;
        end
    end

    assign o_pwm = run && (count < compare);
    assign o_rsp = '{ready: rsp_ready, data: rsp_data, irq: wrap_flag && irq_en,
                     bus_err: rsp_err};

    a_count_in_period: assert property (@(posedge clk) disable iff (!rst_n)
        run && $past(run) && $stable(period) |-> count <= period);

endmodule

`default_nettype wire

//--- design/uart_mem.sv
`timescale 1ns/1ps
`default_nettype none

module uart_mem (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        i_enable,
    input  wire lt100_pkg::lt100_req_t i_req,
    input  wire                        i_rx_pin,
    output lt100_pkg::lt100_rsp_t      o_rsp,
    output logic                       o_tx_pin
);
    import lt100_pkg::*;

    typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    lt100_req_t req_q;
    logic       acc_q;
    data_t      div;
    data_t      rd_data;
    logic       bad;
    logic       tx_load;
    logic       rx_take;
    logic       rsp_ready;
    logic       rsp_err;
    data_t      rsp_data;
    tx_state_t  tx_state;
    logic [9:0] tx_frame;
    logic [3:0] tx_bits;
    data_t      tx_cnt;
    logic       tx_busy;
    rx_state_t  rx_state;
    logic       rx_meta;
    logic       rx_sync;
    data_t      rx_cnt;
    logic [2:0] rx_bits;
    logic [7:0] rx_shift;
    logic [7:0] rx_data;
    logic       rx_valid;

    assign tx_busy  = (tx_state == TX_SHIFT);
    assign o_tx_pin = tx_frame[0];

    always_ff @(posedge clk) begin
        if (i_enable) begin
            req_q <= i_req;
        end
    end

    always_comb begin
        rd_data = '0;
        bad     = 1'b0;
        tx_load = 1'b0;
        rx_take = 1'b0;
        case (req_q.offset)
            UART_TXDATA: begin
                bad     = req_q.wr_en && tx_busy;
                tx_load = acc_q && req_q.wr_en && !tx_busy;
            end
            UART_STATUS: begin
                rd_data[UART_STAT_TX_BUSY]  = tx_busy;
                rd_data[UART_STAT_RX_VALID] = rx_valid;
            end
            UART_RXDATA: begin
                rd_data[7:0] = rx_data;
                rx_take      = acc_q && !req_q.wr_en;
            end
            UART_DIV: rd_data = div;
            default:  bad = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_q     <= 1'b0;
            rsp_ready <= 1'b0;
            rsp_err   <= 1'b0;
            div       <= UART_DIV_RESET;
            tx_state  <= TX_IDLE;
            tx_frame  <= '1;
            tx_bits   <= '0;
            tx_cnt    <= '0;
            rx_state  <= RX_IDLE;
            rx_meta   <= 1'b1;
            rx_sync   <= 1'b1;
            rx_cnt    <= '0;
            rx_bits   <= '0;
            rx_valid  <= 1'b0;
        end else begin
            acc_q     <= i_enable;
            rsp_ready <= acc_q;
            rsp_err   <= acc_q && bad;
            if (acc_q && req_q.wr_en && req_q.offset == UART_DIV) begin
                div <= req_q.data;
            end

            // --------------------------------------------------
            // Transmitter, start + 8 data + stop, LSB first
            // --------------------------------------------------
            if (tx_load) begin
                tx_state <= TX_SHIFT;
                tx_frame <= {1'b1, req_q.data[7:0], 1'b0};
                tx_bits  <= 4'd10;
                tx_cnt   <= '0;
            end else if (tx_busy) begin
                if (tx_cnt + 1'b1 >= div) begin
                    tx_cnt   <= '0;
                    tx_frame <= {1'b1, tx_frame[9:1]};
                    tx_bits  <= tx_bits - 1'b1;
                    if (tx_bits == 4'd1) begin
                        tx_state <= TX_IDLE;
                    end
                end else begin
                    tx_cnt <= tx_cnt + 1'b1;
                end
            end

            // --------------------------------------------------
            // Receiver, sampled at mid-bit
            // --------------------------------------------------
            rx_meta <= i_rx_pin;
            rx_sync <= rx_meta;
            if (rx_take) begin
                rx_valid <= 1'b0;
            end
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_sync) begin
                        rx_state <= RX_START;
                    end
                end
                RX_START: begin
                    if (rx_cnt + 1'b1 >= (div >> 1)) begin
                        // Start bit gone at mid-bit means a glitch
                        rx_cnt   <= '0;
                        rx_bits  <= '0;
                        rx_state <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (rx_cnt + 1'b1 >= div) begin
                        rx_cnt   <= '0;
                        rx_shift <= {rx_sync, rx_shift[7:1]};
                        rx_bits  <= rx_bits + 1'b1;
                        if (rx_bits == 3'd7) begin
                            rx_state <= RX_STOP;
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (rx_cnt + 1'b1 >= div) begin
                        rx_state <= RX_IDLE;
                        if (rx_sync) begin
                            rx_data  <= rx_shift;
                            rx_valid <= 1'b1;
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (acc_q) begin
            rsp_data <= rd_data;
        end
    end

    assign o_rsp = '{ready: rsp_ready, data: rsp_data, irq: rx_valid, bus_err: rsp_err};

    a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        tx_state == TX_IDLE |-> o_tx_pin);

endmodule

`default_nettype wire

//--- design/lt100_bus.sv
`timescale 1ns/1ps
`default_nettype none

module lt100_bus (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   i_enable,
    input  wire                   i_wr_en,
    input  wire lt100_pkg::addr_t i_addr,
    input  wire lt100_pkg::data_t i_data,
    input  wire lt100_pkg::be_t   i_be,
    output logic                  o_ready,
    output lt100_pkg::data_t      o_data,
    output logic                  o_irq,
    output logic                  o_bus_err,
    input  wire                   i_rx_pin,
    output logic                  o_tx_pin,
    output logic                  o_pwm
);
    import lt100_pkg::*;

    region_t    region;
    region_t    region_q;
    lt100_req_t req;
    lt100_rsp_t rsp_bram;
    lt100_rsp_t rsp_timer;
    lt100_rsp_t rsp_uart;
    lt100_rsp_t rsp_sel;
    bus_state_t state;
    logic       start;
    logic       strb_bram;
    logic       strb_timer;
    logic       strb_uart;
    logic       mapped_q;
    logic       load_rsp;

    // --------------------------------------------------
    // Request capture and decode
    // --------------------------------------------------
    assign region = i_addr[ADDR_WIDTH-1 -: REGION_WIDTH];
    assign req    = '{wr_en: i_wr_en, offset: i_addr[OFFSET_WIDTH-1:0], data: i_data, be: i_be};

    // One strobe per access decoded straight from the raw address
    assign start      = i_enable && !o_ready && (state == BUS_IDLE);
    assign strb_bram  = start && (region == REGION_BRAM);
    assign strb_timer = start && (region == REGION_TIMER);
    assign strb_uart  = start && (region == REGION_UART);

    sp_bram u_bram (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_enable (strb_bram),
        .i_req    (req),
        .o_rsp    (rsp_bram)
    );

    timer_mem u_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_enable (strb_timer),
        .i_req    (req),
        .o_rsp    (rsp_timer),
        .o_pwm    (o_pwm)
    );

    uart_mem u_uart (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_enable (strb_uart),
        .i_req    (req),
        .i_rx_pin (i_rx_pin),
        .o_rsp    (rsp_uart),
        .o_tx_pin (o_tx_pin)
    );

    // --------------------------------------------------
    // Response return
    // --------------------------------------------------
    always_comb begin
        rsp_sel  = '0;
        mapped_q = 1'b1;
        case (region_q)
            REGION_BRAM:  rsp_sel = rsp_bram;
            REGION_TIMER: rsp_sel = rsp_timer;
            REGION_UART:  rsp_sel = rsp_uart;
            default:      mapped_q = 1'b0;
        endcase
    end

    // Unmapped regions answer on the edge after capture
    assign load_rsp = (state == BUS_WAIT) && i_enable && (!mapped_q || rsp_sel.ready);
    assign o_irq    = rsp_bram.irq | rsp_timer.irq | rsp_uart.irq;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= BUS_IDLE;
            o_ready   <= 1'b0;
            o_bus_err <= 1'b0;
        end else if (!i_enable) begin
            // CPU ended or aborted the access
            state     <= BUS_IDLE;
            o_ready   <= 1'b0;
            o_bus_err <= 1'b0;
        end else if (start) begin
            state <= BUS_WAIT;
        end else if (load_rsp) begin
            state     <= BUS_IDLE;
            o_ready   <= 1'b1;
            o_bus_err <= !mapped_q || rsp_sel.bus_err;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            region_q <= region;
        end
        if (load_rsp) begin
            o_data <= rsp_sel.data;
        end
    end

    a_strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({strb_uart, strb_timer, strb_bram}));

    // Ready rises two edges after a peripheral strobe and one after an unmapped capture
    a_ready_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(o_ready) |-> $past(start, 2) || $past(start, 3));

endmodule

`default_nettype wire

//--- sim/tb_lt100_bus.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lt100_bus;
    import lt100_pkg::*;

    localparam int CLK_PERIOD = 20;
    // UART loopback is ~160 cycles per byte at DIV 16, RAM and timer a few thousand
    localparam int MAX_CYCLES = 200000;

    logic  clk;
    logic  rst_n;
    logic  i_enable;
    logic  i_wr_en;
    addr_t i_addr;
    data_t i_data;
    be_t   i_be;
    logic  o_ready;
    data_t o_data;
    logic  o_irq;
    logic  o_bus_err;
    logic  o_pwm;
    wire   serial_line;

    logic [31:0] seed;
    int          value_errors;
    int          protocol_errors;
    int          cycles;
    data_t       ram_model [BRAM_DEPTH];

    // TX looped straight back into RX
    lt100_bus lt100_bus_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_enable  (i_enable),
        .i_wr_en   (i_wr_en),
        .i_addr    (i_addr),
        .i_data    (i_data),
        .i_be      (i_be),
        .o_ready   (o_ready),
        .o_data    (o_data),
        .o_irq     (o_irq),
        .o_bus_err (o_bus_err),
        .i_rx_pin  (serial_line),
        .o_tx_pin  (serial_line),
        .o_pwm     (o_pwm)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic data_t next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 16);
    endfunction

    // Expected RAM word after a write with byte enables
    function automatic data_t merge_bytes(data_t old_word, data_t new_word, be_t be);
        data_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic report_mismatch(input string name, input data_t expected, input data_t actual);
        value_errors++;
        $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        protocol_errors++;
        $display("%s", what);
    endtask

    // One CPU access; lat counts edges from the first sampling edge to o_ready
    task automatic bus_access(input logic wr, input addr_t addr, input data_t wdata,
                              input be_t be, input int hold, output data_t rdata,
                              output logic err, output int lat);
        @(posedge clk);
        i_enable <= 1'b1;
        i_wr_en  <= wr;
        i_addr   <= addr;
        i_data   <= wdata;
        i_be     <= be;
        @(posedge clk);
        lat = 0;
        @(negedge clk);
        while (!o_ready) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        rdata = o_data;
        err   = o_bus_err;
        repeat (hold) begin
            @(negedge clk);
            if (o_ready !== 1'b1) report_failure("o_ready fell while i_enable was still held");
        end
        @(posedge clk);
        i_enable <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (o_ready !== 1'b0) report_failure("o_ready still high one edge after i_enable dropped");
    endtask

    task automatic wait_uart_status(input int bit_pos, input logic value);
        data_t status;
        logic  err;
        int    lat;
        do begin
            bus_access(1'b0, {REGION_UART, UART_STATUS}, '0, 4'hf, 0, status, err, lat);
        end while (status[bit_pos] !== value);
    endtask

    initial begin
        data_t      rd;
        data_t      wdata;
        logic       err;
        logic       wr;
        int         lat;
        int         idx;
        be_t        be;
        addr_t      addr;
        data_t      period_m;
        data_t      compare_m;
        data_t      expected_high;
        int         high_cycles;
        logic [7:0] tx_byte;

        seed            = 32'hc8f9;
        value_errors    = 0;
        protocol_errors = 0;
        rst_n           = 1'b0;
        i_enable        = 1'b0;
        i_wr_en         = 1'b0;
        i_addr          = '0;
        i_data          = '0;
        i_be            = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (o_ready !== 1'b0 || o_bus_err !== 1'b0 || o_irq !== 1'b0 || o_pwm !== 1'b0
            || serial_line !== 1'b1) begin
            report_failure("Outputs are not in their idle state after reset");
        end

        // Ready two edges after the sampling edge, held while enable stays high
        for (int r = 0; r < 3; r++) begin
            bus_access(1'b0, {region_t'(r), 28'h4}, '0, 4'hf, 3, rd, err, lat);
            if (lat != 2) report_mismatch("access_timing", 2, lat);
        end

        // --------------------------------------------------
        // Scratch RAM
        // --------------------------------------------------
        for (int i = 0; i < BRAM_DEPTH; i++) begin
            wdata = next_rand();
            bus_access(1'b1, {REGION_BRAM, offset_t'(i * 4)}, wdata, 4'hf, 0, rd, err, lat);
            ram_model[i] = wdata;
        end
        for (int n = 0; n < 200; n++) begin
            idx   = int'(next_rand() % BRAM_DEPTH);
            be    = be_t'(next_rand());
            wdata = next_rand();
            bus_access(1'b1, {REGION_BRAM, offset_t'(idx * 4)}, wdata, be, 0, rd, err, lat);
            ram_model[idx] = merge_bytes(ram_model[idx], wdata, be);
            if (err !== 1'b0) report_mismatch("ram_write_err", 0, err);
            if (next_rand() % 2 == 0) begin
                idx = int'(next_rand() % BRAM_DEPTH);
                bus_access(1'b0, {REGION_BRAM, offset_t'(idx * 4)}, '0, 4'hf, 0, rd, err, lat);
                if (rd !== ram_model[idx]) report_mismatch("ram_read", ram_model[idx], rd);
            end
        end
        // Beyond 1 KiB: error, and the aliased word must stay put
        for (int n = 0; n < 8; n++) begin
            addr = {REGION_BRAM, offset_t'(next_rand()) | 28'h400};
            bus_access(1'b1, addr, next_rand(), 4'hf, 0, rd, err, lat);
            if (err !== 1'b1) report_mismatch("ram_oor_err", 1, err);
            idx = int'(addr[9:2]);
            bus_access(1'b0, {REGION_BRAM, offset_t'(idx * 4)}, '0, 4'hf, 0, rd, err, lat);
            if (rd !== ram_model[idx]) report_mismatch("ram_oor_alias", ram_model[idx], rd);
        end

        // --------------------------------------------------
        // Timer
        // --------------------------------------------------
        period_m  = next_rand() % 64;
        compare_m = next_rand() % 64;
        bus_access(1'b1, {REGION_TIMER, TMR_PERIOD}, period_m, 4'hf, 0, rd, err, lat);
        bus_access(1'b1, {REGION_TIMER, TMR_COMPARE}, compare_m, 4'hf, 0, rd, err, lat);
        bus_access(1'b0, {REGION_TIMER, TMR_PERIOD}, '0, 4'hf, 0, rd, err, lat);
        if (rd !== period_m) report_mismatch("timer_period", period_m, rd);
        bus_access(1'b0, {REGION_TIMER, TMR_COMPARE}, '0, 4'hf, 0, rd, err, lat);
        if (rd !== compare_m) report_mismatch("timer_compare", compare_m, rd);
        bus_access(1'b1, {REGION_TIMER, TMR_COUNT}, 32'h5, 4'hf, 0, rd, err, lat);
        if (err !== 1'b1) report_mismatch("timer_count_write_err", 1, err);

        // Run with irq enabled, then count PWM high cycles over one period
        bus_access(1'b1, {REGION_TIMER, TMR_CTRL}, 32'h3, 4'hf, 0, rd, err, lat);
        high_cycles = 0;
        repeat (period_m + 1) begin
            @(negedge clk);
            if (o_pwm) high_cycles++;
        end
        expected_high = (compare_m < period_m + 1) ? compare_m : period_m + 1;
        if (high_cycles != expected_high) report_mismatch("timer_pwm", expected_high, high_cycles);
        if (o_irq !== 1'b1) report_mismatch("timer_irq_set", 1, o_irq);
        // Stop so no new wrap races the clear
        bus_access(1'b1, {REGION_TIMER, TMR_CTRL}, 32'h2, 4'hf, 0, rd, err, lat);
        bus_access(1'b1, {REGION_TIMER, TMR_STATUS}, 32'h1, 4'hf, 0, rd, err, lat);
        if (o_irq !== 1'b0) report_mismatch("timer_irq_clear", 0, o_irq);

        // --------------------------------------------------
        // UART loopback
        // --------------------------------------------------
        bus_access(1'b0, {REGION_UART, UART_DIV}, '0, 4'hf, 0, rd, err, lat);
        if (rd !== 32'd16) report_mismatch("uart_div_reset", 16, rd);
        for (int n = 0; n < 8; n++) begin
            tx_byte = 8'(next_rand());
            wait_uart_status(UART_STAT_TX_BUSY, 1'b0);
            bus_access(1'b1, {REGION_UART, UART_TXDATA}, {24'h0, tx_byte}, 4'hf, 0, rd, err, lat);
            if (err !== 1'b0) report_mismatch("uart_tx_write_err", 0, err);
            bus_access(1'b0, {REGION_UART, UART_STATUS}, '0, 4'hf, 0, rd, err, lat);
            if (rd[UART_STAT_TX_BUSY]) begin
                bus_access(1'b1, {REGION_UART, UART_TXDATA}, {24'h0, ~tx_byte}, 4'hf, 0,
                           rd, err, lat);
                if (err !== 1'b1) report_mismatch("uart_tx_busy_err", 1, err);
            end else begin
                report_failure("Transmitter was not busy right after a TXDATA write");
            end
            wait_uart_status(UART_STAT_RX_VALID, 1'b1);
            if (o_irq !== 1'b1) report_mismatch("uart_irq_set", 1, o_irq);
            bus_access(1'b0, {REGION_UART, UART_RXDATA}, '0, 4'hf, 0, rd, err, lat);
            if (rd !== {24'h0, tx_byte}) report_mismatch("uart_rx_byte", {24'h0, tx_byte}, rd);
            if (o_irq !== 1'b0) report_mismatch("uart_irq_clear", 0, o_irq);
        end

        // --------------------------------------------------
        // Unmapped regions, then a full RAM sweep
        // --------------------------------------------------
        for (int n = 0; n < 20; n++) begin
            addr = {region_t'(3 + next_rand() % 13), offset_t'((next_rand() % BRAM_DEPTH) * 4)};
            wr   = (next_rand() % 2) != 0;
            bus_access(wr, addr, next_rand(), 4'hf, 0, rd, err, lat);
            if (err !== 1'b1) report_mismatch("unmapped_err", 1, err);
            if (rd !== '0) report_mismatch("unmapped_data", 0, rd);
        end
        for (int i = 0; i < BRAM_DEPTH; i++) begin
            bus_access(1'b0, {REGION_BRAM, offset_t'(i * 4)}, '0, 4'hf, 0, rd, err, lat);
            if (rd !== ram_model[i]) report_mismatch("ram_after_unmapped", ram_model[i], rd);
        end

        $display("Errors: %0d value mismatches, %0d protocol failures",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
design/lt100_pkg.sv
design/sp_bram.sv
design/timer_mem.sv
design/uart_mem.sv
design/lt100_bus.sv
sim/tb_lt100_bus.sv

//--- Bender.yml
package:
  name: lt100_periph

sources:
  - design/lt100_pkg.sv
  - design/sp_bram.sv
  - design/timer_mem.sv
  - design/uart_mem.sv
  - design/lt100_bus.sv
  - target: simulation
    files:
      - sim/tb_lt100_bus.sv
